// ==== hw/lpcPkg.sv ====
package lpcPkg;

	//////////////////////////////////////////////////////////////////////
	// Frame and coefficient geometry
	//////////////////////////////////////////////////////////////////////

	// Samples per 5 ms frame at 8 kHz
	localparam int frameLen = 40;
	// LPC order, highest autocorrelation lag
	localparam int lpcOrder = 10;
	localparam int numCoef = lpcOrder + 1;

	localparam int sampleW = 16;
	localparam int coefW = 32;
	// Width of the external result address
	localparam int addrW = 12;

	// Sequencer state codes
	localparam logic [1:0] stIdle = 2'd0;
	localparam logic [1:0] stCorr = 2'd1;
	localparam logic [1:0] stDrain = 2'd2;

	//////////////////////////////////////////////////////////////////////
	// Lag window, Q15
	//////////////////////////////////////////////////////////////////////

	// Entry 0 doubles as white-noise correction on r[0]
	// Entries 1..10 follow the G.729 Gaussian window
	localparam logic [15:0] lagTable [0:numCoef-1] = '{
		16'd32767, 16'd32728, 16'd32619, 16'd32438, 16'd32187, 16'd31867,
		16'd31480, 16'd31029, 16'd30517, 16'd29946, 16'd29321
	};

	// Coefficient word, seen whole or in double-precision halves
	// hi is signed, lo is the unsigned remainder
	typedef union packed {
		logic signed [coefW-1:0] whole;
		struct packed {
			logic signed [15:0] hi;
			logic [15:0] lo;
		} dp;
	} acWord;

endpackage

// ==== hw/frameBuffer.sv ====
`timescale 1ns/1ps

module frameBuffer (
	input  logic clock,
	input  logic rstN,
	input  logic start,
	input  logic signed [lpcPkg::sampleW-1:0] xn,
	input  logic bankSel,
	input  logic bankRelease,
	input  logic [5:0] rdIdxA,
	input  logic [5:0] rdIdxB,
	output logic frameReady,
	output logic readyBank,
	output logic overrun,
	output logic signed [lpcPkg::sampleW-1:0] sampA,
	output logic signed [lpcPkg::sampleW-1:0] sampB
);

	// Ping-pong sample store, two banks of one frame each
	logic signed [lpcPkg::sampleW-1:0] mem [0:1][0:lpcPkg::frameLen-1];

	// Next write slot in the filling bank
	logic [5:0] wrIdx;
	// Bank currently being filled
	logic fillBank;
	// One full flag per bank
	logic [1:0] full;
	logic wrEn;
	logic lastWr;

	// Sample is taken only if the filling bank is free
	assign wrEn = start & ~full[fillBank];
	// Both banks busy, sample lost on this cycle
	assign overrun = start & full[fillBank];
	assign lastWr = wrEn && (wrIdx == 6'(lpcPkg::frameLen - 1));

	//////////////////////////////////////////////////////////////////////
	// Write side control
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!rstN) begin
			wrIdx <= '0;
			fillBank <= 1'b0;
			full <= 2'b00;
			frameReady <= 1'b0;
			readyBank <= 1'b0;
		end else begin
			frameReady <= 1'b0;
			// Sequencer done with this bank
			if (bankRelease)
				full[bankSel] <= 1'b0;
			if (wrEn) begin
				if (lastWr) begin
					// Frame complete, hand over and swap banks
					wrIdx <= '0;
					full[fillBank] <= 1'b1;
					fillBank <= ~fillBank;
					frameReady <= 1'b1;
					readyBank <= fillBank;
				end else begin
					wrIdx <= wrIdx + 6'd1;
				end
			end
		end
	end

	// Storage and registered dual read port
	always_ff @(posedge clock) begin
		if (wrEn)
			mem[fillBank][wrIdx] <= xn;
		sampA <= mem[bankSel][rdIdxA];
		sampB <= mem[bankSel][rdIdxB];
	end

	// Sequencer only frees a bank holding a complete frame
	assert property (@(posedge clock) disable iff (!rstN) bankRelease |-> full[bankSel])
		else $error("bankRelease on empty bank %0d", bankSel);

endmodule

// ==== hw/lpcSequencer.sv ====
`timescale 1ns/1ps

module lpcSequencer (
	input  logic clock,
	input  logic rstN,
	input  logic frameReady,
	input  logic readyBank,
	input  logic acDone,
	input  logic winValid,
	input  logic [3:0] winIdx,
	output logic acGo,
	output logic bankSel,
	output logic bankRelease,
	output logic done
);

	logic [1:0] state;
	// One full bank waiting while busy
	logic pending;
	logic pendBank;
	logic lastWin;

	// Final windowed coefficient closes the frame
	assign lastWin = winValid && (winIdx == 4'(lpcPkg::lpcOrder));

	always_ff @(posedge clock) begin
		if (!rstN) begin
			state <= lpcPkg::stIdle;
			pending <= 1'b0;
			pendBank <= 1'b0;
			bankSel <= 1'b0;
			acGo <= 1'b0;
			bankRelease <= 1'b0;
			done <= 1'b0;
		end else begin
			acGo <= 1'b0;
			bankRelease <= 1'b0;
			done <= 1'b0;
			case (state)
				lpcPkg::stIdle: begin
					if (pending) begin
						// Waiting bank goes first
						bankSel <= pendBank;
						acGo <= 1'b1;
						state <= lpcPkg::stCorr;
						pending <= frameReady;
						pendBank <= readyBank;
					end else if (frameReady) begin
						bankSel <= readyBank;
						acGo <= 1'b1;
						state <= lpcPkg::stCorr;
					end
				end
				lpcPkg::stCorr: begin
					if (frameReady) begin
						pending <= 1'b1;
						pendBank <= readyBank;
					end
					if (acDone)
						state <= lpcPkg::stDrain;
				end
				default: begin
					if (frameReady) begin
						pending <= 1'b1;
						pendBank <= readyBank;
					end
					// Lag window pipeline empty, free the bank
					if (lastWin) begin
						bankRelease <= 1'b1;
						done <= 1'b1;
						state <= lpcPkg::stIdle;
					end
				end
			endcase
		end
	end

	// Last window only arrives once the engine has finished
	assert property (@(posedge clock) disable iff (!rstN)
		lastWin |-> state == lpcPkg::stDrain)
		else $error("final window coefficient before acDone");

endmodule

// ==== hw/autocorr.sv ====
`timescale 1ns/1ps

module autocorr (
	input  logic clock,
	input  logic rstN,
	input  logic acGo,
	input  logic signed [lpcPkg::sampleW-1:0] sampA,
	input  logic signed [lpcPkg::sampleW-1:0] sampB,
	output logic [5:0] rdIdxA,
	output logic [5:0] rdIdxB,
	output logic coefValid,
	output logic [3:0] coefIdx,
	output lpcPkg::acWord coefValue,
	output logic acDone
);

	logic busy;
	// Current lag
	logic [3:0] k;
	// Current sample index, runs k..39
	logic [5:0] n;
	// One idle read slot at the end of each lag
	logic drainCyc;
	// Sample pair on sampA/sampB is valid
	logic macEn;
	logic issue;
	logic signed [39:0] acc;
	logic signed [31:0] prod;
	logic signed [39:0] sum;
	logic signed [31:0] satSum;

	// Idle indices point at x[0], so the acGo cycle is the first read
	assign rdIdxA = n;
	assign rdIdxB = n - 6'(k);
	assign issue = acGo | (busy & ~drainCyc);

	//////////////////////////////////////////////////////////////////////
	// MAC datapath
	//////////////////////////////////////////////////////////////////////

	assign prod = sampA * sampB;
	assign sum = macEn ? acc + 40'(prod) : acc;

	// Clamp to signed 32 bits
	always_comb begin
		if (sum[39:31] == {9{sum[39]}})
			satSum = sum[31:0];
		else if (sum[39])
			satSum = 32'sh8000_0000;
		else
			satSum = 32'sh7FFF_FFFF;
	end

	//////////////////////////////////////////////////////////////////////
	// Index walk and output
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!rstN) begin
			busy <= 1'b0;
			k <= '0;
			n <= '0;
			drainCyc <= 1'b0;
			macEn <= 1'b0;
			acc <= '0;
			coefValid <= 1'b0;
			acDone <= 1'b0;
		end else begin
			macEn <= issue;
			coefValid <= 1'b0;
			acDone <= 1'b0;
			// Last product folds in on the drain cycle
			if (drainCyc)
				acc <= '0;
			else if (macEn)
				acc <= sum;
			if (acGo && !busy) begin
				busy <= 1'b1;
				n <= 6'd1;
			end else if (busy) begin
				if (drainCyc) begin
					drainCyc <= 1'b0;
					coefValid <= 1'b1;
					if (k == 4'(lpcPkg::lpcOrder)) begin
						// All eleven lags out
						busy <= 1'b0;
						k <= '0;
						n <= '0;
						acDone <= 1'b1;
					end else begin
						k <= k + 4'd1;
						n <= 6'(k) + 6'd1;
					end
				end else if (n == 6'(lpcPkg::frameLen - 1)) begin
					drainCyc <= 1'b1;
				end else begin
					n <= n + 6'd1;
				end
			end
		end
	end

	// Result payload
	always_ff @(posedge clock) begin
		if (busy && drainCyc) begin
			coefIdx <= k;
			coefValue.whole <= satSum;
		end
	end

	// Sequencer never restarts a run in progress
	assert property (@(posedge clock) disable iff (!rstN) acGo |-> !busy)
		else $error("acGo while busy at lag %0d", k);

endmodule

// ==== hw/lagWindow.sv ====
`timescale 1ns/1ps

module lagWindow (
	input  logic clock,
	input  logic rstN,
	input  logic coefValid,
	input  logic [3:0] coefIdx,
	input  lpcPkg::acWord coefValue,
	output logic winValid,
	output logic [3:0] winIdx,
	output lpcPkg::acWord winValue
);

	logic v1;
	logic [3:0] idx1;
	// Partial products of the double-precision halves
	logic signed [31:0] pHi;
	logic [31:0] pLo;
	logic [15:0] lagW;
	logic signed [47:0] total;

	assign lagW = lpcPkg::lagTable[coefIdx];

	//////////////////////////////////////////////////////////////////////
	// Stage one, split multiply
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!rstN)
			v1 <= 1'b0;
		else
			v1 <= coefValid;
	end

	always_ff @(posedge clock) begin
		idx1 <= coefIdx;
		// Window constant is positive, zero-extended as signed
		pHi <= coefValue.dp.hi * $signed({1'b0, lagW});
		pLo <= coefValue.dp.lo * lagW;
	end

	//////////////////////////////////////////////////////////////////////
	// Stage two, recombine and scale
	//////////////////////////////////////////////////////////////////////

	// hi*2^16 + lo gives the full product exactly
	assign total = (48'(pHi) <<< 16) + 48'(pLo);

	always_ff @(posedge clock) begin
		if (!rstN)
			winValid <= 1'b0;
		else
			winValid <= v1;
	end

	always_ff @(posedge clock) begin
		winIdx <= idx1;
		// Back to Q0, arithmetic shift then truncate
		winValue.whole <= 32'(total >>> 15);
	end

endmodule

// ==== hw/outBuffer.sv ====
`timescale 1ns/1ps

module outBuffer (
	input  logic clock,
	input  logic rstN,
	input  logic winValid,
	input  logic [3:0] winIdx,
	input  lpcPkg::acWord winValue,
	input  logic [lpcPkg::addrW-1:0] outBufAddr,
	output logic [lpcPkg::coefW-1:0] out
);

	// Windowed r[0..10]
	lpcPkg::acWord coefMem [0:lpcPkg::numCoef-1];

	always_ff @(posedge clock) begin
		if (!rstN) begin
			for (int i = 0; i < lpcPkg::numCoef; i++)
				coefMem[i] <= '0;
			out <= '0;
		end else begin
			if (winValid && (winIdx < 4'(lpcPkg::numCoef)))
				coefMem[winIdx] <= winValue;
			// Registered read, zero past the last coefficient
			if (outBufAddr < lpcPkg::addrW'(lpcPkg::numCoef))
				out <= coefMem[outBufAddr[3:0]].whole;
			else
				out <= '0;
		end
	end

endmodule

// ==== hw/g729LpcTop.sv ====
`timescale 1ns/1ps

module g729LpcTop (
	input  logic clock,
	input  logic rstN,
	input  logic start,
	input  logic signed [lpcPkg::sampleW-1:0] xn,
	input  logic [lpcPkg::addrW-1:0] outBufAddr,
	output logic [lpcPkg::coefW-1:0] out,
	output logic done,
	output logic overrun
);

	// Frame buffer handshake
	logic frameReady;
	logic readyBank;
	logic bankSel;
	logic bankRelease;
	// Autocorrelation read port
	logic [5:0] rdIdxA;
	logic [5:0] rdIdxB;
	logic signed [lpcPkg::sampleW-1:0] sampA;
	logic signed [lpcPkg::sampleW-1:0] sampB;
	logic acGo;
	logic acDone;
	// Coefficient streams
	logic coefValid;
	logic [3:0] coefIdx;
	lpcPkg::acWord coefValue;
	logic winValid;
	logic [3:0] winIdx;
	lpcPkg::acWord winValue;

	frameBuffer iFrameBuffer (
		.clock(clock), .rstN(rstN), .start(start), .xn(xn),
		.bankSel(bankSel), .bankRelease(bankRelease),
		.rdIdxA(rdIdxA), .rdIdxB(rdIdxB),
		.frameReady(frameReady), .readyBank(readyBank), .overrun(overrun),
		.sampA(sampA), .sampB(sampB)
	);

	lpcSequencer iLpcSequencer (
		.clock(clock), .rstN(rstN), .frameReady(frameReady), .readyBank(readyBank),
		.acDone(acDone), .winValid(winValid), .winIdx(winIdx),
		.acGo(acGo), .bankSel(bankSel), .bankRelease(bankRelease), .done(done)
	);

	autocorr iAutocorr (
		.clock(clock), .rstN(rstN), .acGo(acGo), .sampA(sampA), .sampB(sampB),
		.rdIdxA(rdIdxA), .rdIdxB(rdIdxB), .coefValid(coefValid), .coefIdx(coefIdx),
		.coefValue(coefValue), .acDone(acDone)
	);

	// Two-cycle window multiply
	lagWindow iLagWindow (
		.clock(clock), .rstN(rstN), .coefValid(coefValid), .coefIdx(coefIdx),
		.coefValue(coefValue), .winValid(winValid), .winIdx(winIdx), .winValue(winValue)
	);

	outBuffer iOutBuffer (
		.clock(clock), .rstN(rstN), .winValid(winValid), .winIdx(winIdx),
		.winValue(winValue), .outBufAddr(outBufAddr), .out(out)
	);

endmodule

// ==== testbench/tbG729Lpc.sv ====
`timescale 1ns/1ps

module tbG729Lpc;

	// One autocorrelation run, sum over lags of (frameLen - k + 1)
	localparam int acCycles = lpcPkg::numCoef * (lpcPkg::frameLen + 1)
		- (lpcPkg::lpcOrder * lpcPkg::numCoef) / 2;
	// Fill, correlate, window, hand-off
	localparam int frameCycles = lpcPkg::frameLen + acCycles + 8;
	localparam int numAddr = 1 << lpcPkg::addrW;
	// Six processed frames, one quiet window, the full address sweep, slack
	localparam int maxCycles = 7 * frameCycles + numAddr + 1000;
	localparam int numFrames = 7;
	localparam longint satMax = 64'sd2147483647;
	localparam longint satMin = -64'sd2147483648;

	logic clock = 1'b0;
	logic rstN;
	logic start;
	logic signed [lpcPkg::sampleW-1:0] xn;
	logic [lpcPkg::addrW-1:0] outBufAddr;
	logic [lpcPkg::coefW-1:0] out;
	logic done;
	logic overrun;

	// Every frame sent, kept for the model
	logic signed [lpcPkg::sampleW-1:0] frameData [0:numFrames-1][0:lpcPkg::frameLen-1];
	logic [31:0] rngState = 32'd80438;
	int cycles = 0;
	int doneCount = 0;
	int overrunCount = 0;
	int errCount = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int testErrBase = 0;
	// Windows where done, overrun or a saturated r[0] are legal
	logic expectDone = 1'b0;
	logic expectOverrun = 1'b0;
	logic satTest = 1'b0;

	g729LpcTop u_dut (
		.clock(clock), .rstN(rstN), .start(start), .xn(xn),
		.outBufAddr(outBufAddr), .out(out), .done(done), .overrun(overrun)
	);

	always #2 clock = ~clock;

	//////////////////////////////////////////////////////////////////////
	// Event counters and run limit
	//////////////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		if (rstN && done)
			doneCount++;
		if (rstN && overrun)
			overrunCount++;
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles >= maxCycles) begin
			$display("Timeout after %0d cycles, the DUT stopped finishing frames", cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Protocol assertions
	//////////////////////////////////////////////////////////////////////

	assert property (@(posedge clock) disable iff (!rstN) !expectDone |-> !done)
		else begin
			errCount++;
			$display("Unexpected done pulse at cycle %0d", cycles);
		end

	assert property (@(posedge clock) disable iff (!rstN) !expectOverrun |-> !overrun)
		else begin
			errCount++;
			$display("Unexpected overrun pulse at cycle %0d", cycles);
		end

	// Strobe, one cycle only
	assert property (@(posedge clock) disable iff (!rstN) done |=> !done)
		else begin
			errCount++;
			$display("done held high for more than one cycle");
		end

	// r[0] of the constant frame clamps to the top of the 32-bit range
	assert property (@(posedge clock) disable iff (!rstN)
		satTest && u_dut.coefValid && u_dut.coefIdx == 4'd0
		|-> u_dut.coefValue.whole == 32'sh7FFF_FFFF)
		else begin
			errCount++;
			$display("MISMATCH saturation r0 expected 7fffffff actual %08h",
				u_dut.coefValue.whole);
		end

	//////////////////////////////////////////////////////////////////////
	// Stimulus source and reference model
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Full-width sum, clamp, then Q15 window with floor shift
	function automatic logic [31:0] windowedCoef(input int f, input int k);
		longint acc;
		longint sat;
		int n;
		acc = 0;
		for (n = k; n < lpcPkg::frameLen; n++)
			acc += longint'(frameData[f][n]) * longint'(frameData[f][n-k]);
		sat = (acc > satMax) ? satMax : (acc < satMin) ? satMin : acc;
		return 32'((sat * longint'(lpcPkg::lagTable[k])) >>> 15);
	endfunction

	// f below zero means cleared buffer
	function automatic logic [31:0] expectedWord(input int f, input int a);
		if (f < 0 || a > lpcPkg::lpcOrder)
			return '0;
		return windowedCoef(f, a);
	endfunction

	// Scaled down, r[0] stays below the clamp
	task automatic fillRandom(input int f);
		int n;
		for (n = 0; n < lpcPkg::frameLen; n++) begin
			rngState = xorshift(rngState);
			frameData[f][n] = $signed(rngState[15:0]) >>> 3;
		end
	endtask

	// Consecutive frames at one sample per cycle
	task automatic sendFrames(input int first, input int count);
		int f;
		int n;
		for (f = first; f < first + count; f++)
			for (n = 0; n < lpcPkg::frameLen; n++) begin
				@(posedge clock);
				#1;
				start = 1'b1;
				xn = frameData[f][n];
			end
		@(posedge clock);
		#1;
		start = 1'b0;
		xn = '0;
	endtask

	task automatic waitDoneCount(input int target);
		while (doneCount < target)
			@(negedge clock);
	endtask

	// One address per cycle, out checked one cycle behind
	task automatic readRange(input string name, input int lo, input int hi, input int f);
		int a;
		logic [31:0] expV;
		for (a = lo; a <= hi + 1; a++) begin
			@(posedge clock);
			#1;
			if (a > lo) begin
				expV = expectedWord(f, a - 1);
				assert (out === expV)
					else begin
						errCount++;
						$display("MISMATCH %s addr %0d expected %08h actual %08h",
							name, a - 1, expV, out);
					end
			end
			if (a <= hi)
				outBufAddr = lpcPkg::addrW'(a);
		end
	endtask

	task automatic checkCount(input string name, input int expected, input int actual);
		assert (actual == expected)
			else begin
				errCount++;
				$display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
			end
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		if (errCount != testErrBase) begin
			testsFailed++;
			$display("test %-12s failed", name);
		end else begin
			$display("test %-12s passed", name);
		end
		testErrBase = errCount;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int base;
		int ovBase;
		int i;
		rstN = 1'b0;
		start = 1'b0;
		xn = '0;
		outBufAddr = '0;
		fillRandom(0);
		// Most negative sample everywhere
		for (i = 0; i < lpcPkg::frameLen; i++)
			frameData[1][i] = 16'sh8000;
		for (i = 2; i < numFrames; i++)
			fillRandom(i);
		repeat (5) @(posedge clock);
		#1;
		rstN = 1'b1;

		readRange("reset", 0, 15, -1);
		repeat (10) @(posedge clock);
		finishTest("reset");

		base = doneCount;
		expectDone = 1'b1;
		sendFrames(0, 1);
		waitDoneCount(base + 1);
		expectDone = 1'b0;
		readRange("random", 0, lpcPkg::lpcOrder, 0);
		finishTest("random");

		base = doneCount;
		expectDone = 1'b1;
		satTest = 1'b1;
		sendFrames(1, 1);
		waitDoneCount(base + 1);
		expectDone = 1'b0;
		satTest = 1'b0;
		readRange("saturation", 0, lpcPkg::lpcOrder, 1);
		finishTest("saturation");

		// Second frame fills the other bank during the first run
		base = doneCount;
		expectDone = 1'b1;
		sendFrames(2, 2);
		waitDoneCount(base + 1);
		readRange("backToBack", 0, lpcPkg::lpcOrder, 2);
		waitDoneCount(base + 2);
		expectDone = 1'b0;
		readRange("backToBack", 0, lpcPkg::lpcOrder, 3);
		checkCount("backToBack dones", base + 2, doneCount);
		finishTest("backToBack");

		// Third frame meets two full banks and is lost
		base = doneCount;
		ovBase = overrunCount;
		expectDone = 1'b1;
		expectOverrun = 1'b1;
		sendFrames(4, 3);
		expectOverrun = 1'b0;
		checkCount("overrun pulses", lpcPkg::frameLen, overrunCount - ovBase);
		waitDoneCount(base + 2);
		expectDone = 1'b0;
		readRange("overrun", 0, lpcPkg::lpcOrder, 5);
		repeat (frameCycles) @(posedge clock);
		checkCount("overrun dones", base + 2, doneCount);
		finishTest("overrun");

		readRange("addrRange", 0, numAddr - 1, 5);
		finishTest("addrRange");

		$display("Summary: %0d tests, %0d failed, %0d failed checks",
			testsRun, testsFailed, errCount);
		if (errCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== g729Lpc.f ====
hw/lpcPkg.sv
hw/frameBuffer.sv
hw/lpcSequencer.sv
hw/autocorr.sv
hw/lagWindow.sv
hw/outBuffer.sv
hw/g729LpcTop.sv
testbench/tbG729Lpc.sv

// ==== Makefile ====
# Verilator build and run for the G.729 LPC front end

VERILATOR ?= verilator
TOP ?= tbG729Lpc
FILELIST ?= g729Lpc.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert -Wall
PASS_MSG ?= NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only if the pass message shows up as a line of its own
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
